/* sram_soc.f */
hw/sram_bus_pkg.sv
hw/sram_dev_pkg.sv
hw/sram_ctrl.sv
hw/axil_sram_port.sv
hw/sram_subsys_top.sv
test/sram_chip_model.sv
test/sram_ctrl_asserts.sv
test/tb_sram_subsys.sv

/* Makefile */
TOP := tb_sram_subsys
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sram_soc.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f sram_soc.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Testbench reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "Run ended without a result line, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* test/tb_sram_subsys.sv */
`timescale 1ns/1ns
module tb_sram_subsys;
    import sram_bus_pkg::*;
    import sram_dev_pkg::*;

    localparam int ADDR_W         = 10;
    localparam int WAIT_CYCLES    = 2;
    localparam int BANK_BIT       = ADDR_W + 2;  // 0 base, 1 ext
    localparam int RESET_CYCLES   = 10;
    localparam int N_RAND         = 64;          // Also the size of addr_set, 6 bit pick
    localparam int N_STRB         = 32;
    localparam int N_BANK         = 8;
    localparam int N_ERR          = 8;
    localparam int N_BP           = 4;
    localparam int TXN_TOTAL      = 2*N_RAND + 2*N_STRB + 5*N_BANK + 3*N_ERR + 3*N_BP;
    localparam int TIMEOUT_CYCLES = 2 * TXN_TOTAL * (WAIT_CYCLES + 10) + RESET_CYCLES;

    logic        clk_in;
    logic        rst;
    axil_m2s_t   axil_req;
    axil_s2m_t   axil_rsp;
    sram_pins_t  base_ram;
    sram_pins_t  ext_ram;
    logic [31:0] base_ram_dq_in;
    logic [31:0] ext_ram_dq_in;
    logic [15:0] chip_rd [4];                    // Base lo, base hi, ext lo, ext hi
    logic        chip_drv [4];

    logic [31:0] ref_mem [2**(ADDR_W+1)];        // Bank bit above the word address
    logic [31:0] addr_set [N_RAND];              // In-range addresses already written
    logic [31:0] lfsr = 32'h0d7f_bfe7;
    axil_resp_e  exp_bresp_q [$];
    axil_resp_e  exp_rresp_q [$];
    logic [31:0] exp_rdata_q [$];
    int          error_cnt = 0;
    int          check_cnt = 0;
    int          test_cnt = 0;
    int          test_fail_cnt = 0;
    int          test_err_base = 0;
    int          cycle_cnt = 0;

    sram_subsys_top #(
        .ADDR_W     (ADDR_W),
        .WAIT_CYCLES(WAIT_CYCLES)
    ) i_dut (
        .clk_in        (clk_in),
        .rst           (rst),
        .axil_req      (axil_req),
        .axil_rsp      (axil_rsp),
        .base_ram      (base_ram),
        .base_ram_dq_in(base_ram_dq_in),
        .ext_ram       (ext_ram),
        .ext_ram_dq_in (ext_ram_dq_in)
    );

    // Two 16-bit chips per bank
    for (genvar c = 0; c < 4; c++) begin : g_chip
        sram_pins_t pins_c;
        assign pins_c = (c < 2) ? base_ram : ext_ram;
        sram_chip_model #(
            .ADDR_W(ADDR_W)
        ) i_chip (
            .addr (pins_c.addr[ADDR_W-1:0]),
            .ce_n (pins_c.ce_n),
            .oe_n (pins_c.oe_n),
            .we_n (pins_c.we_n),
            .lb_n (pins_c.be_n[2*(c%2)]),
            .ub_n (pins_c.be_n[2*(c%2)+1]),
            .dq_wr(pins_c.dq_out[16*(c%2) +: 16]),
            .dq_rd(chip_rd[c]),
            .drv  (chip_drv[c])
        );
    end

    // Bus resolution, idle bus reads as zero
    assign base_ram_dq_in = base_ram.dq_oe ? base_ram.dq_out :
                            {chip_drv[1] ? chip_rd[1] : 16'h0, chip_drv[0] ? chip_rd[0] : 16'h0};
    assign ext_ram_dq_in  = ext_ram.dq_oe ? ext_ram.dq_out :
                            {chip_drv[3] ? chip_rd[3] : 16'h0, chip_drv[2] ? chip_rd[2] : 16'h0};

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;             // 8 ns period
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);              // One step per bit
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] rand_addr();
        logic              bank;
        logic [ADDR_W-1:0] word;
        logic [1:0]        off;
        bank = 1'(rand_bits(1));
        word = ADDR_W'(rand_bits(ADDR_W));
        off  = 2'(rand_bits(2));                 // Byte offset, ignored by DUT
        return 32'({bank, word, off});
    endfunction

    function automatic logic [31:0] pick_addr();
        logic [5:0] idx;
        idx = 6'(rand_bits(6));
        return addr_set[idx];
    endfunction

    // Address map and strobe merge on the expected memory
    function automatic logic [31:0] ref_access(input logic wr, input logic [31:0] addr,
                                               input logic [31:0] wdata, input logic [3:0] strb,
                                               output axil_resp_e resp);
        logic [ADDR_W:0] idx;
        logic [31:0]     word;
        idx = addr[BANK_BIT:2];
        if (addr[31:BANK_BIT+1] != '0) begin     // Out of range, memory untouched
            resp = RESP_SLVERR;
            return '0;
        end
        resp = RESP_OKAY;
        word = ref_mem[idx];
        if (!wr) begin
            return word;
        end
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                word[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        ref_mem[idx] = word;
        return word;
    endfunction

    task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("Error at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input axil_resp_e got, input axil_resp_e exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("Error at %0t ns: %s is %s, expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic start_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        axil_resp_e resp;
        void'(ref_access(1'b1, addr, data, strb, resp));
        exp_bresp_q.push_back(resp);
        axil_req.awaddr  <= addr;
        axil_req.awvalid <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= strb;
        axil_req.wvalid  <= 1'b1;
    endtask

    task automatic start_read(input logic [31:0] addr);
        axil_resp_e  resp;
        logic [31:0] data;
        data = ref_access(1'b0, addr, '0, 4'h0, resp);
        exp_rresp_q.push_back(resp);
        exp_rdata_q.push_back(data);
        axil_req.araddr  <= addr;
        axil_req.arvalid <= 1'b1;
    endtask

    task automatic wait_aw();
        do begin
            @(posedge clk_in);
        end while (!(axil_rsp.awready && axil_rsp.wready));
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
    endtask

    task automatic wait_ar();
        do begin
            @(posedge clk_in);
        end while (!axil_rsp.arready);
        axil_req.arvalid <= 1'b0;
    endtask

    // Response must sit still while the master stalls
    task automatic hold_resp(input logic is_read, input int cycles);
        axil_resp_e  resp0;
        logic [31:0] data0;
        resp0 = is_read ? axil_rsp.rresp : axil_rsp.bresp;
        data0 = axil_rsp.rdata;
        repeat (cycles) begin
            @(posedge clk_in);
            check_flag(is_read ? axil_rsp.rvalid : axil_rsp.bvalid, 1'b1, "valid under stall");
            check_resp(is_read ? axil_rsp.rresp : axil_rsp.bresp, resp0, "resp under stall");
            if (is_read) begin
                check_rdata(axil_rsp.rdata, data0, "rdata under stall");
            end
            check_flag(axil_rsp.arready | axil_rsp.awready, 1'b0, "accept under stall");
        end
    endtask

    task automatic finish_b(input int stall);
        do begin
            @(posedge clk_in);
        end while (!axil_rsp.bvalid);
        hold_resp(1'b0, stall);
        axil_req.bready <= 1'b1;
        @(posedge clk_in);                       // Handshake edge
        axil_req.bready <= 1'b0;
    endtask

    task automatic finish_r(input int stall);
        do begin
            @(posedge clk_in);
        end while (!axil_rsp.rvalid);
        hold_resp(1'b1, stall);
        axil_req.rready <= 1'b1;
        @(posedge clk_in);
        axil_req.rready <= 1'b0;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        start_write(addr, data, strb);
        wait_aw();
        finish_b(0);
    endtask

    task automatic axi_read(input logic [31:0] addr);
        start_read(addr);
        wait_ar();
        finish_r(0);
    endtask

    task automatic begin_test();
        test_err_base = error_cnt;
    endtask

    task automatic end_test(input string name);
        int errs;
        @(posedge clk_in);                       // Compare process sees the last response
        errs = error_cnt - test_err_base;
        test_cnt++;
        if (errs == 0) begin
            $display("test %0d %s: passed", test_cnt, name);
        end else begin
            test_fail_cnt++;
            $display("test %0d %s: failed with %0d errors", test_cnt, name, errs);
        end
    endtask

    // Compare process, one expectation per completed response
    always @(posedge clk_in) begin
        if (!rst && axil_rsp.bvalid && axil_req.bready) begin
            if (exp_bresp_q.size() == 0) begin
                error_cnt++;
                $display("Write response at %0t ns with no write outstanding", $time);
            end else begin
                check_resp(axil_rsp.bresp, exp_bresp_q.pop_front(), "bresp");
            end
        end
        if (!rst && axil_rsp.rvalid && axil_req.rready) begin
            if (exp_rresp_q.size() == 0) begin
                error_cnt++;
                $display("Read response at %0t ns with no read outstanding", $time);
            end else begin
                check_resp(axil_rsp.rresp, exp_rresp_q.pop_front(), "rresp");
                check_rdata(axil_rsp.rdata, exp_rdata_q.pop_front(), "rdata");
            end
        end
    end

    always @(posedge clk_in) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] a2;
        logic [31:0] d;
        logic [3:0]  st;
        int          bit_pos;
        int          stall;
        axil_req <= '0;
        rst      <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_in);
        rst <= 1'b0;

        begin_test();
        repeat (3) begin
            @(posedge clk_in);
            check_flag(axil_rsp.awready | axil_rsp.wready | axil_rsp.arready, 1'b0, "ready");
            check_flag(axil_rsp.bvalid | axil_rsp.rvalid, 1'b0, "valid");
            check_flag(base_ram.ce_n & base_ram.oe_n & base_ram.we_n & (&base_ram.be_n), 1'b1,
                       "base strobes");
            check_flag(ext_ram.ce_n & ext_ram.oe_n & ext_ram.we_n & (&ext_ram.be_n), 1'b1,
                       "ext strobes");
            check_flag(base_ram.dq_oe | ext_ram.dq_oe, 1'b0, "dq_oe");
        end
        end_test("idle after reset");

        begin_test();
        for (int i = 0; i < N_RAND; i++) begin
            addr_set[i] = rand_addr();
            d = rand_bits(32);
            axi_write(addr_set[i], d, 4'hf);
        end
        for (int i = 0; i < N_RAND; i++) begin
            axi_read(addr_set[i]);
        end
        end_test("random full-word writes");

        begin_test();
        for (int i = 0; i < N_STRB; i++) begin
            a  = pick_addr();
            d  = rand_bits(32);
            st = 4'(rand_bits(4));
            axi_write(a, d, st);                 // Merge into old word
            axi_read(a);
        end
        end_test("byte strobe merge");

        begin_test();
        for (int i = 0; i < N_BANK; i++) begin
            a  = rand_addr() & ~(32'h1 << BANK_BIT);
            a2 = a | (32'h1 << BANK_BIT);        // Same word offset in ext
            d  = rand_bits(32);
            axi_write(a, d, 4'hf);
            d  = rand_bits(32);
            axi_write(a2, d, 4'hf);
            d  = rand_bits(32);
            axi_write(a, d, 4'hf);
            axi_read(a2);
            axi_read(a);
        end
        end_test("bank independence");

        begin_test();
        for (int i = 0; i < N_ERR; i++) begin
            a       = pick_addr();
            bit_pos = BANK_BIT + 1 + int'(rand_bits(5)) % (31 - BANK_BIT);
            a2      = a | (32'h1 << bit_pos);    // Aliases a if the bit were dropped
            d       = rand_bits(32);
            axi_write(a2, d, 4'hf);
            axi_read(a2);
            axi_read(a);
        end
        end_test("decode error");

        begin_test();
        for (int i = 0; i < N_BP; i++) begin
            a  = pick_addr();
            d  = rand_bits(32);
            st = 4'(rand_bits(4));
            start_write(a, d, st);
            wait_aw();
            start_read(a);                       // Left pending through the B stall
            stall = 1 + int'(rand_bits(3));
            finish_b(stall);
            wait_ar();
            a2 = pick_addr();
            d  = rand_bits(32);
            start_write(a2, d, 4'hf);            // Pending through the R stall
            stall = 1 + int'(rand_bits(3));
            finish_r(stall);
            wait_aw();
            finish_b(0);
        end
        end_test("response back-pressure");

        $display("%0d tests, %0d failed, %0d checks, %0d errors", test_cnt, test_fail_cnt,
                 check_cnt, error_cnt);
        if (error_cnt == 0 && test_fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* test/sram_ctrl_asserts.sv */
`timescale 1ns/1ns
module sram_ctrl_asserts (
    input logic                     clk_in,
    input logic                     rst,
    input sram_dev_pkg::sram_pins_t pins
);

    // Never read and write at once
    a_strobe_excl: assert property (@(posedge clk_in) disable iff (rst) pins.oe_n || pins.we_n)
        else $error("oe_n and we_n low in the same cycle");

    // Write strobe only with the chips selected
    a_we_ce: assert property (@(posedge clk_in) disable iff (rst) !pins.we_n |-> !pins.ce_n)
        else $error("we_n low while ce_n high");

    // Address and lanes frozen under a strobe
    a_addr_stable: assert property (@(posedge clk_in) disable iff (rst)
        (!pins.oe_n || !pins.we_n) |-> ($stable(pins.addr) && $stable(pins.be_n)))
        else $error("addr or be_n moved while a strobe was low");

endmodule

bind sram_ctrl sram_ctrl_asserts i_asserts (
    .clk_in(clk_in),
    .rst   (rst),
    .pins  (pins)
);

/* test/sram_chip_model.sv */
`timescale 1ns/1ns
module sram_chip_model #(
    parameter int ADDR_W = 20                         // Word address bits of the chip
) (
    input  logic [ADDR_W-1:0] addr,
    input  logic              ce_n,
    input  logic              oe_n,
    input  logic              we_n,
    input  logic              lb_n,                   // Enables dq[7:0]
    input  logic              ub_n,                   // Enables dq[15:8]
    input  logic [15:0]       dq_wr,                  // Bus value while the controller drives
    output logic [15:0]       dq_rd,
    output logic              drv                     // Chip owns the bus
);

    logic [15:0] mem [2**ADDR_W];

    // Output buffers on only in a read cycle
    assign drv   = !ce_n && !oe_n && we_n;
    assign dq_rd = drv ? mem[addr] : 16'h0000;

    // Write completes on the rising edge of we_n
    always @(posedge we_n) begin
        if (!ce_n) begin
            if (!lb_n) begin
                mem[addr][7:0] <= dq_wr[7:0];
            end
            if (!ub_n) begin
                mem[addr][15:8] <= dq_wr[15:8];
            end
        end
    end

endmodule

/* hw/sram_subsys_top.sv */
`timescale 1ns/1ns
module sram_subsys_top #(
    parameter int ADDR_W      = 20,                   // At most SRAM_AW_MAX
    parameter int WAIT_CYCLES = 2                     // At least 1
) (
    input  logic                     clk_in,
    input  logic                     rst,
    input  sram_bus_pkg::axil_m2s_t  axil_req,
    output sram_bus_pkg::axil_s2m_t  axil_rsp,
    output sram_dev_pkg::sram_pins_t base_ram,
    input  logic [31:0]              base_ram_dq_in,
    output sram_dev_pkg::sram_pins_t ext_ram,
    input  logic [31:0]              ext_ram_dq_in
);
    import sram_dev_pkg::*;

    sram_req_t   base_req;                            // Port to base bank
    sram_req_t   ext_req;                             // Port to ext bank
    logic        base_req_valid;
    logic        ext_req_valid;
    logic        base_done;
    logic        ext_done;
    logic [31:0] base_rdata;
    logic [31:0] ext_rdata;

    axil_sram_port #(
        .ADDR_W(ADDR_W)
    ) i_port (
        .clk_in        (clk_in),
        .rst           (rst),
        .axil_req      (axil_req),
        .axil_rsp      (axil_rsp),
        .base_req      (base_req),
        .base_req_valid(base_req_valid),
        .base_done     (base_done),
        .base_rdata    (base_rdata),
        .ext_req       (ext_req),
        .ext_req_valid (ext_req_valid),
        .ext_done      (ext_done),
        .ext_rdata     (ext_rdata)
    );

    // Lower bank, bank bit 0
    sram_ctrl #(
        .ADDR_W     (ADDR_W),
        .WAIT_CYCLES(WAIT_CYCLES)
    ) i_base_ctrl (
        .clk_in   (clk_in),
        .rst      (rst),
        .req      (base_req),
        .req_valid(base_req_valid),
        .dq_in    (base_ram_dq_in),
        .done     (base_done),
        .rdata    (base_rdata),
        .pins     (base_ram)
    );

    // Upper bank, bank bit 1
    sram_ctrl #(
        .ADDR_W     (ADDR_W),
        .WAIT_CYCLES(WAIT_CYCLES)
    ) i_ext_ctrl (
        .clk_in   (clk_in),
        .rst      (rst),
        .req      (ext_req),
        .req_valid(ext_req_valid),
        .dq_in    (ext_ram_dq_in),
        .done     (ext_done),
        .rdata    (ext_rdata),
        .pins     (ext_ram)
    );

endmodule

/* hw/axil_sram_port.sv */
`timescale 1ns/1ns
module axil_sram_port #(
    parameter int ADDR_W = 20                         // Word address bits per bank
) (
    input  logic                    clk_in,
    input  logic                    rst,
    input  sram_bus_pkg::axil_m2s_t axil_req,
    output sram_bus_pkg::axil_s2m_t axil_rsp,
    output sram_dev_pkg::sram_req_t base_req,
    output logic                    base_req_valid,
    input  logic                    base_done,
    input  logic [31:0]             base_rdata,
    output sram_dev_pkg::sram_req_t ext_req,
    output logic                    ext_req_valid,
    input  logic                    ext_done,
    input  logic [31:0]             ext_rdata
);
    import sram_bus_pkg::*;
    import sram_dev_pkg::*;

    typedef enum logic [1:0] {
        PS_IDLE  = 2'd0,                              // Waiting for AR or AW plus W
        PS_ISSUE = 2'd1,                              // Decode, pulse req_valid
        PS_WAIT  = 2'd2,                              // Bank busy
        PS_RESP  = 2'd3                               // B or R held for master
    } port_state_e;

    port_state_e        state;
    logic               rd_take;                      // AR handshake this cycle
    logic               wr_take;                      // AW and W handshake this cycle
    logic               wr_q;                         // Latched direction
    logic [31:0]        addr_q;                       // Latched byte address
    logic [31:0]        wdata_q;
    logic [3:0]         strb_q;
    logic               bank_sel;                     // 0 base, 1 ext
    logic               range_err;                    // Bits above bank select
    logic               issue;
    logic               bank_done;
    logic [31:0]        bank_rdata;
    logic               bvalid_q;
    logic               rvalid_q;
    axil_resp_e         resp_q;                       // Shared by B and R
    logic [31:0]        rdata_q;
    sram_req_t          req_s;

    // Reads win when both are pending
    assign rd_take = (state == PS_IDLE) && axil_req.arvalid;
    assign wr_take = (state == PS_IDLE) && !axil_req.arvalid &&
                     axil_req.awvalid && axil_req.wvalid;

    // Address map: [1:0] ignored, word above, then bank bit
    assign bank_sel  = addr_q[ADDR_W+2];
    assign range_err = |addr_q[31:ADDR_W+3];

    assign issue      = (state == PS_ISSUE) && !range_err;
    assign bank_done  = bank_sel ? ext_done : base_done;
    assign bank_rdata = bank_sel ? ext_rdata : base_rdata;

    // Same payload to both banks, only one valid fires
    always_comb begin
        req_s.write     = wr_q;
        req_s.word_addr = SRAM_AW_MAX'(addr_q[ADDR_W+1:2]);
        req_s.wdata     = wdata_q;
        req_s.be        = wr_q ? strb_q : '1;         // Reads fetch the full word
    end

    assign base_req       = req_s;
    assign ext_req        = req_s;
    assign base_req_valid = issue && !bank_sel;
    assign ext_req_valid  = issue && bank_sel;

    // Control FSM
    always_ff @(posedge clk_in) begin
        if (rst) begin
            state    <= PS_IDLE;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            case (state)
                PS_IDLE: begin
                    if (rd_take || wr_take) begin
                        state <= PS_ISSUE;
                    end
                end
                PS_ISSUE: begin
                    if (range_err) begin                  // Answer without touching a bank
                        state    <= PS_RESP;
                        bvalid_q <= wr_q;
                        rvalid_q <= !wr_q;
                    end else begin
                        state <= PS_WAIT;
                    end
                end
                PS_WAIT: begin
                    if (bank_done) begin
                        state    <= PS_RESP;
                        bvalid_q <= wr_q;
                        rvalid_q <= !wr_q;
                    end
                end
                PS_RESP: begin
                    if ((bvalid_q && axil_req.bready) || (rvalid_q && axil_req.rready)) begin
                        state    <= PS_IDLE;
                        bvalid_q <= 1'b0;
                        rvalid_q <= 1'b0;
                    end
                end
                default: state <= PS_IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge clk_in) begin
        if (rd_take) begin
            addr_q <= axil_req.araddr;
            wr_q   <= 1'b0;
        end else if (wr_take) begin
            addr_q  <= axil_req.awaddr;
            wdata_q <= axil_req.wdata;
            strb_q  <= axil_req.wstrb;
            wr_q    <= 1'b1;
        end
        if ((state == PS_ISSUE) && range_err) begin
            resp_q  <= RESP_SLVERR;
            rdata_q <= '0;                                // Error reads return zero
        end else if ((state == PS_WAIT) && bank_done) begin
            resp_q  <= RESP_OKAY;
            rdata_q <= bank_rdata;
        end
    end

    always_comb begin
        axil_rsp.awready = wr_take;                       // One cycle pulse with wready
        axil_rsp.wready  = wr_take;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.bresp   = resp_q;
        axil_rsp.arready = rd_take;
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = resp_q;
    end

endmodule

/* hw/sram_ctrl.sv */
`timescale 1ns/1ns
module sram_ctrl #(
    parameter int ADDR_W      = 20,                   // Word address bits actually wired
    parameter int WAIT_CYCLES = 2                     // Strobe low time in cycles
) (
    input  logic                    clk_in,
    input  logic                    rst,
    input  sram_dev_pkg::sram_req_t req,
    input  logic                    req_valid,        // Single pulse, only while idle
    input  logic [31:0]             dq_in,            // Resolved bus from the chips
    output logic                    done,             // Pulse in the hold cycle
    output logic [31:0]             rdata,            // Valid with done on reads
    output sram_dev_pkg::sram_pins_t pins
);
    import sram_dev_pkg::*;

    localparam int CNT_W = (WAIT_CYCLES > 1) ? $clog2(WAIT_CYCLES) : 1;

    sram_state_e            state;
    logic [CNT_W-1:0]       wait_cnt;                 // Access cycles left minus one
    logic                   wr_q;                     // Direction of current access
    logic                   ce_n_q;
    logic                   oe_n_q;
    logic                   we_n_q;
    logic [SRAM_BE_W-1:0]   be_n_q;
    logic                   dq_oe_q;
    logic [SRAM_AW_MAX-1:0] addr_q;
    logic [SRAM_DW-1:0]     dq_out_q;
    logic                   take;                     // Accept a new request
    logic                   strobe_end;               // Last cycle with strobe low

    assign take       = (state == ST_IDLE) && req_valid;
    assign strobe_end = (state == ST_ACCESS) && (wait_cnt == '0);

    // Sequence: setup, WAIT_CYCLES strobe, hold
    always_ff @(posedge clk_in) begin
        if (rst) begin
            state    <= ST_IDLE;
            wait_cnt <= '0;
            wr_q     <= 1'b0;
            ce_n_q   <= 1'b1;
            oe_n_q   <= 1'b1;
            we_n_q   <= 1'b1;
            be_n_q   <= '1;
            dq_oe_q  <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        state   <= ST_SETUP;
                        wr_q    <= req.write;
                        ce_n_q  <= 1'b0;              // Select both chips
                        be_n_q  <= ~req.be;           // Lanes 1:0 low chip, 3:2 high chip
                        dq_oe_q <= req.write;         // Drive data from setup on
                    end
                end
                ST_SETUP: begin
                    state    <= ST_ACCESS;
                    wait_cnt <= CNT_W'(WAIT_CYCLES - 1);
                    oe_n_q   <= wr_q;                 // Read strobe
                    we_n_q   <= !wr_q;                // Write strobe
                end
                ST_ACCESS: begin
                    if (strobe_end) begin
                        state  <= ST_HOLD;
                        oe_n_q <= 1'b1;
                        we_n_q <= 1'b1;               // Rising we_n latches write data
                        done   <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                ST_HOLD: begin
                    state   <= ST_IDLE;
                    ce_n_q  <= 1'b1;
                    be_n_q  <= '1;
                    dq_oe_q <= 1'b0;                  // Release bus after hold
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Address and write data stay put from setup through hold
    always_ff @(posedge clk_in) begin
        if (take) begin
            addr_q   <= SRAM_AW_MAX'(req.word_addr[ADDR_W-1:0]);
            dq_out_q <= req.wdata;
        end
    end

    // Read data sampled at end of strobe
    always_ff @(posedge clk_in) begin
        if (strobe_end && !wr_q) begin
            rdata <= dq_in;
        end
    end

    always_comb begin
        pins.addr   = addr_q;
        pins.ce_n   = ce_n_q;
        pins.oe_n   = oe_n_q;
        pins.we_n   = we_n_q;
        pins.be_n   = be_n_q;
        pins.dq_out = dq_out_q;
        pins.dq_oe  = dq_oe_q;
    end

endmodule

/* hw/sram_dev_pkg.sv */
package sram_dev_pkg;

    // Bank geometry
    localparam int SRAM_AW_MAX = 20;                  // Widest word address per bank
    localparam int SRAM_DW     = 32;                  // Two 16-bit chips side by side
    localparam int SRAM_BE_W   = SRAM_DW / 8;         // Lower and upper byte of each chip

    // One word access handed from the AXI port to a bank controller
    typedef struct packed {
        logic                   write;                // 1 write, 0 read
        logic [SRAM_AW_MAX-1:0] word_addr;            // Zero extended word address
        logic [SRAM_DW-1:0]     wdata;
        logic [SRAM_BE_W-1:0]   be;                   // Active high lane enables
    } sram_req_t;

    // Bank pins, data bus split for simulation
    typedef struct packed {
        logic [SRAM_AW_MAX-1:0] addr;                 // Shared by both chips
        logic                   ce_n;                 // Chip enable
        logic                   oe_n;                 // Output enable, read strobe
        logic                   we_n;                 // Write strobe
        logic [SRAM_BE_W-1:0]   be_n;                 // [1:0] low chip, [3:2] high chip
        logic [SRAM_DW-1:0]     dq_out;               // Write data toward chips
        logic                   dq_oe;                // High while controller owns dq
    } sram_pins_t;

    // Bank controller sequence
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,                             // Chip deselected
        ST_SETUP  = 3'd1,                             // Address settles, strobes high
        ST_ACCESS = 3'd2,                             // oe_n or we_n low
        ST_HOLD   = 3'd3                              // Strobe released, address kept
    } sram_state_e;

endpackage

/* hw/sram_bus_pkg.sv */
package sram_bus_pkg;

    // AXI4-Lite widths as seen by the subsystem
    localparam int AXIL_AW = 32;                      // Byte address
    localparam int AXIL_DW = 32;                      // Word data
    localparam int AXIL_SW = AXIL_DW / 8;             // One strobe per byte lane

    // B and R channel response codes
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,                          // Normal completion
        RESP_SLVERR = 2'b10                           // Outside both banks
    } axil_resp_e;

    // Master to slave, all five channels in one bundle
    typedef struct packed {
        logic [AXIL_AW-1:0] awaddr;                   // Write address
        logic               awvalid;
        logic [AXIL_DW-1:0] wdata;                    // Write data
        logic [AXIL_SW-1:0] wstrb;                    // Byte lane strobes
        logic               wvalid;
        logic               bready;                   // Master takes B
        logic [AXIL_AW-1:0] araddr;                   // Read address
        logic               arvalid;
        logic               rready;                   // Master takes R
    } axil_m2s_t;

    // Slave to master
    typedef struct packed {
        logic               awready;
        logic               wready;
        logic               bvalid;
        axil_resp_e         bresp;                    // Write status
        logic               arready;
        logic               rvalid;
        logic [AXIL_DW-1:0] rdata;                    // Zero on SLVERR
        axil_resp_e         rresp;                    // Read status
    } axil_s2m_t;

endpackage
